/* source/serdes_types_pkg.sv */
package serdes_types_pkg;

    typedef logic        [1:0]  symbol_t;  // pam4 symbol index 0..3
    typedef logic signed [7:0]  level_t;   // line voltage code
    typedef logic        [15:0] count_t;   // bit error count

    // nominal eye levels, indexed by symbol
    localparam level_t pam4_levels [0:3] = '{
        -8'sd96,   // symbol 0
        -8'sd32,   // symbol 1
        8'sd32,    // symbol 2
        8'sd96     // symbol 3
    };

    // decision thresholds midway between levels
    localparam level_t slice_low  = -8'sd64;
    localparam level_t slice_mid  = 8'sd0;
    localparam level_t slice_high = 8'sd64;

    localparam logic [6:0] prbs_seed = 7'h7f;  // all ones, tx and rx alike

endpackage

/* source/noise_cfg_pkg.sv */
package noise_cfg_pkg;

    typedef logic signed [7:0] noise_t;       // additive noise sample
    typedef logic        [4:0] noise_addr_t;  // table index and memory address

    localparam int noise_depth = 32;  // default table size, power of two

    // loader sequence, one pass only
    typedef enum logic [1:0] {
        wait_load,  // idle until load pulse
        loading,    // walking memory addresses
        playing     // table full, noise active
    } load_state_t;

endpackage

/* source/pam4_transmitter.sv */
`timescale 1ns/10ps

module pam4_transmitter (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     prbs_en,   // level, holds everything when low
    output serdes_types_pkg::level_t tx_level,  // mapped pam4 level
    output logic                     tx_valid   // one strobe per symbol
);

    logic [6:0]                prbs_q;       // lfsr state
    logic                      prbs_bit;     // bit leaving the lfsr this cycle
    logic                      phase_q;      // set while the pair msb is waiting
    logic                      first_bit_q;  // msb of the pair being built
    logic [1:0]                pair;         // first-sent bit on top
    serdes_types_pkg::symbol_t symbol;       // gray coded index

    assign prbs_bit = prbs_q[6] ^ prbs_q[5];  // x^7 + x^6 + 1
    assign pair     = {first_bit_q, prbs_bit};

    // gray map 00 01 11 10 onto symbols 0 1 2 3
    assign symbol = {pair[1], pair[1] ^ pair[0]};

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            prbs_q   <= serdes_types_pkg::prbs_seed;
            phase_q  <= 1'b0;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= prbs_en & phase_q;  // second bit goes out now
            if (prbs_en) begin
                prbs_q  <= {prbs_q[5:0], prbs_bit};  // one bit per clock
                phase_q <= ~phase_q;                 // toggles first/second bit
            end
        end
    end

    // pair msb capture and level lookup
    always_ff @(posedge clock) begin
        if (prbs_en && !phase_q) begin
            first_bit_q <= prbs_bit;  // held across a pause
        end
        if (prbs_en && phase_q) begin
            tx_level <= serdes_types_pkg::pam4_levels[symbol];  // table lookup
        end
    end

endmodule

/* source/noise_source.sv */
`timescale 1ns/10ps

module noise_source #(
    parameter int NOISE_DEPTH = noise_cfg_pkg::noise_depth  // power of two, 32 max
) (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         noise_load,    // start pulse
    input  logic                         tx_valid,      // advances playback
    input  noise_cfg_pkg::noise_t        mem_data,      // arrives one cycle after addr
    output noise_cfg_pkg::noise_addr_t   mem_addr,
    output noise_cfg_pkg::noise_t        noise_sample,  // zero before the table is full
    output logic                         noise_ready
);

    localparam noise_cfg_pkg::noise_addr_t last_addr =
        noise_cfg_pkg::noise_addr_t'(NOISE_DEPTH - 1);

    noise_cfg_pkg::load_state_t state;
    noise_cfg_pkg::noise_t      noise_table [NOISE_DEPTH];  // captured samples
    noise_cfg_pkg::noise_addr_t wr_idx;      // address issued last cycle
    logic                       wr_pending;  // mem_data valid for wr_idx
    noise_cfg_pkg::noise_addr_t play_ptr;    // current playback entry

    assign noise_ready  = (state == noise_cfg_pkg::playing);
    assign noise_sample = noise_ready ? noise_table[play_ptr] : '0;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= noise_cfg_pkg::wait_load;
            mem_addr   <= '0;
            wr_pending <= 1'b0;
            play_ptr   <= '0;
        end else begin
            wr_pending <= 1'b0;  // only loading keeps it up
            case (state)
                noise_cfg_pkg::wait_load: begin
                    if (noise_load) begin
                        state <= noise_cfg_pkg::loading;  // addr 0 already out
                    end
                end
                noise_cfg_pkg::loading: begin
                    if (wr_pending && wr_idx == last_addr) begin
                        state <= noise_cfg_pkg::playing;  // last word captured
                    end else begin
                        wr_pending <= 1'b1;
                        if (mem_addr != last_addr) begin
                            mem_addr <= mem_addr + 1'b1;  // one address per cycle
                        end
                    end
                end
                noise_cfg_pkg::playing: begin
                    if (tx_valid) begin
                        // wrap at table depth
                        play_ptr <= (play_ptr == last_addr) ? '0 : play_ptr + 1'b1;
                    end
                end
                default: state <= noise_cfg_pkg::wait_load;
            endcase
        end
    end

    // write side lags the address by one cycle
    always_ff @(posedge clock) begin
        wr_idx <= mem_addr;
        if (wr_pending) begin
            noise_table[wr_idx] <= mem_data;
        end
    end

endmodule

/* source/channel_combiner.sv */
`timescale 1ns/10ps

module channel_combiner (
    input  logic                     clock,
    input  logic                     reset_n,
    input  serdes_types_pkg::level_t tx_level,
    input  logic                     tx_valid,
    input  noise_cfg_pkg::noise_t    noise_sample,
    output serdes_types_pkg::level_t line_level,  // clamped sum
    output logic                     line_valid   // tx_valid delayed one cycle
);

    logic signed [8:0]        sum_wide;  // one guard bit
    serdes_types_pkg::level_t sum_sat;

    // sign-extend both operands before adding
    assign sum_wide = {tx_level[7], tx_level} + {noise_sample[7], noise_sample};

    always_comb begin
        if (sum_wide[8] == sum_wide[7]) begin
            sum_sat = sum_wide[7:0];  // fits in eight bits
        end else if (sum_wide[8]) begin
            sum_sat = 8'sh80;  // below -128
        end else begin
            sum_sat = 8'sh7f;  // above +127
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            line_valid <= 1'b0;
        end else begin
            line_valid <= tx_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (tx_valid) begin
            line_level <= sum_sat;  // sampled with the strobe
        end
    end

endmodule

/* source/pam4_receiver.sv */
`timescale 1ns/10ps

module pam4_receiver (
    input  logic                     clock,
    input  logic                     reset_n,
    input  serdes_types_pkg::level_t line_level,
    input  logic                     line_valid,
    output logic [1:0]               rx_bits,     // first-sent bit is msb
    output logic                     rx_valid,
    output serdes_types_pkg::count_t error_count  // saturates at all ones
);

    serdes_types_pkg::symbol_t symbol;     // slicer decision
    logic [1:0]                bits;       // after inverse gray
    logic [6:0]                prbs_q;     // local reference lfsr
    logic [1:0]                exp_bits;   // next two reference bits
    logic [1:0]                bit_diff;   // mismatch mask
    logic [1:0]                err_inc;    // 0..2 errors this symbol
    logic [16:0]               count_sum;  // carry shows overflow

    always_comb begin
        if (line_level < serdes_types_pkg::slice_low) begin
            symbol = 2'd0;
        end else if (line_level < serdes_types_pkg::slice_mid) begin
            symbol = 2'd1;
        end else if (line_level < serdes_types_pkg::slice_high) begin
            symbol = 2'd2;
        end else begin
            symbol = 2'd3;
        end
    end

    assign bits = {symbol[1], symbol[1] ^ symbol[0]};  // 0 1 2 3 -> 00 01 11 10

    // two lfsr steps of x^7 + x^6 + 1 at once
    assign exp_bits  = {prbs_q[6] ^ prbs_q[5], prbs_q[5] ^ prbs_q[4]};
    assign bit_diff  = bits ^ exp_bits;
    assign err_inc   = {1'b0, bit_diff[1]} + {1'b0, bit_diff[0]};
    assign count_sum = {1'b0, error_count} + {15'd0, err_inc};

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            rx_valid    <= 1'b0;
            error_count <= '0;
            prbs_q      <= serdes_types_pkg::prbs_seed;
        end else begin
            rx_valid <= line_valid;
            if (line_valid) begin
                prbs_q      <= {prbs_q[4:0], exp_bits};  // shift in both bits
                error_count <= count_sum[16] ? '1 : count_sum[15:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (line_valid) begin
            rx_bits <= bits;
        end
    end

endmodule

/* source/serdes_link.sv */
`timescale 1ns/10ps

module serdes_link #(
    parameter int NOISE_DEPTH = noise_cfg_pkg::noise_depth  // noise table size
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        prbs_en,      // runs the transmitter
    input  logic        noise_load,   // one-cycle load request
    input  logic [7:0]  mem_data,     // external noise memory read data
    output logic [4:0]  mem_addr,
    output logic        noise_ready,  // table loaded, noise on
    output logic [7:0]  line_level,   // channel output
    output logic        line_valid,
    output logic [1:0]  rx_bits,
    output logic        rx_valid,
    output logic [15:0] error_count
);

    serdes_types_pkg::level_t tx_level;      // clean pam4 level
    logic                     tx_valid;
    noise_cfg_pkg::noise_t    noise_sample;  // per-symbol noise

    pam4_transmitter u_tx (
        .clock    (clock),
        .reset_n  (reset_n),
        .prbs_en  (prbs_en),
        .tx_level (tx_level),
        .tx_valid (tx_valid)
    );

    noise_source #(
        .NOISE_DEPTH (NOISE_DEPTH)
    ) u_noise (
        .clock        (clock),
        .reset_n      (reset_n),
        .noise_load   (noise_load),
        .tx_valid     (tx_valid),      // one sample per symbol
        .mem_data     (mem_data),
        .mem_addr     (mem_addr),
        .noise_sample (noise_sample),
        .noise_ready  (noise_ready)
    );

    channel_combiner u_chan (
        .clock        (clock),
        .reset_n      (reset_n),
        .tx_level     (tx_level),
        .tx_valid     (tx_valid),
        .noise_sample (noise_sample),
        .line_level   (line_level),
        .line_valid   (line_valid)
    );

    pam4_receiver u_rx (
        .clock       (clock),
        .reset_n     (reset_n),
        .line_level  (line_level),
        .line_valid  (line_valid),
        .rx_bits     (rx_bits),
        .rx_valid    (rx_valid),       // two cycles after tx_valid
        .error_count (error_count)
    );

endmodule

/* sim/serdes_link_tb.sv */
`timescale 1ns/10ps

module serdes_link_tb;

    localparam int table_depth = 32;  // noise table size passed to the dut
    localparam int row_total   = 5;
    localparam int pause_len   = 6;   // cycles with prbs_en low
    localparam int drain_len   = 4;   // idle cycles before the final count check
    localparam int mode_zero   = 0;   // no table load
    localparam int mode_fixed  = 1;   // address derived pattern
    localparam int mode_random = 2;   // xorshift values

    // stimulus table with one column per test
    string         row_name    [row_total] = '{"clean", "small_fixed", "small_random",
                                               "large_random", "pause"};
    localparam int row_mode    [row_total] = '{mode_zero, mode_fixed, mode_random,
                                               mode_random, mode_random};
    localparam int row_amp     [row_total] = '{0, 24, 31, 100, 20};  // noise bound
    localparam int row_symbols [row_total] = '{40, 40, 36, 60, 30};
    localparam int row_pause   [row_total] = '{0, 0, 0, 0, 1};

    logic        clock;
    logic        reset_n;
    logic        prbs_en;
    logic        noise_load;
    logic [7:0]  mem_data;
    logic [4:0]  mem_addr;
    logic        noise_ready;
    logic [7:0]  line_level;
    logic        line_valid;
    logic [1:0]  rx_bits;
    logic        rx_valid;
    logic [15:0] error_count;

    logic [7:0]  mem_table [table_depth];  // external noise memory contents
    logic [4:0]  addr_q;                   // address seen one clock earlier
    logic [6:0]  model_prbs;               // reference lfsr
    logic [31:0] rand_state;
    int          model_errors;             // expected bit error total
    string       cur_test;

    always #20 clock = ~clock;  // 40 ns period

    serdes_link #(
        .NOISE_DEPTH (table_depth)
    ) uut (
        .clock       (clock),
        .reset_n     (reset_n),
        .prbs_en     (prbs_en),
        .noise_load  (noise_load),
        .mem_data    (mem_data),
        .mem_addr    (mem_addr),
        .noise_ready (noise_ready),
        .line_level  (line_level),
        .line_valid  (line_valid),
        .rx_bits     (rx_bits),
        .rx_valid    (rx_valid),
        .error_count (error_count)
    );

    // synchronous read memory with data one clock after the address
    initial begin
        mem_data = 8'h00;
        addr_q   = 5'd0;
        forever begin
            @(negedge clock);
            mem_data = mem_table[addr_q];  // uses last cycle's address
            addr_q   = mem_addr;
        end
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // x^7 + x^6 + 1 stepped twice per symbol with the first bit on top
    function automatic logic [1:0] next_model_pair();
        logic b1;
        logic b0;
        b1         = model_prbs[6] ^ model_prbs[5];
        model_prbs = {model_prbs[5:0], b1};
        b0         = model_prbs[6] ^ model_prbs[5];
        model_prbs = {model_prbs[5:0], b0};
        return {b1, b0};
    endfunction

    function automatic logic [1:0] gray_symbol(logic [1:0] pair);
        case (pair)
            2'b00:   return 2'd0;
            2'b01:   return 2'd1;
            2'b11:   return 2'd2;
            default: return 2'd3;  // pair 10
        endcase
    endfunction

    function automatic logic [1:0] symbol_bits(logic [1:0] sym);
        case (sym)
            2'd0:    return 2'b00;
            2'd1:    return 2'b01;
            2'd2:    return 2'b11;
            default: return 2'b10;
        endcase
    endfunction

    function automatic int symbol_level(logic [1:0] sym);
        case (sym)
            2'd0:    return -96;
            2'd1:    return -32;
            2'd2:    return 32;
            default: return 96;
        endcase
    endfunction

    function automatic int clamp_level(int v);
        return (v > 127) ? 127 : ((v < -128) ? -128 : v);
    endfunction

    function automatic logic [1:0] slice_level(int v);
        return (v < -64) ? 2'd0 : (v < 0) ? 2'd1 : (v < 64) ? 2'd2 : 2'd3;
    endfunction

    task automatic check_value(string what, int expected, int actual);
        if (expected != actual) begin
            $display("error: %s %s expected %0d actual %0d", cur_test, what, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic fill_table(int mode, int amp);
        int v;
        for (int a = 0; a < table_depth; a++) begin
            if (mode == mode_fixed) begin
                v = (a * 11 + 5) % (2 * amp + 1) - amp;  // spread over -amp..amp
            end else begin
                rand_state = xorshift(rand_state);
                v = int'(rand_state % 32'(2 * amp + 1)) - amp;
            end
            mem_table[5'(a)] = 8'(v);
        end
    endtask

    // pulse noise_load and follow the address walk until noise_ready
    task automatic load_noise();
        int next_addr;
        next_addr = 0;
        @(negedge clock);
        noise_load = 1'b1;
        @(negedge clock);
        noise_load = 1'b0;
        while (!noise_ready) begin
            if (int'(mem_addr) == next_addr) begin
                next_addr++;
            end else begin
                check_value("mem_addr", next_addr - 1, int'(mem_addr));  // may only hold
            end
            @(negedge clock);
        end
        check_value("addresses issued", table_depth, next_addr);
    endtask

    task automatic drive_prbs(int count, int pause);
        int pause_at;
        pause_at = 2 * (count / 2) + 1;  // odd count leaves a pair half built
        for (int i = 0; i < 2 * count; i++) begin
            @(negedge clock);
            if (pause != 0 && i == pause_at) begin
                prbs_en = 1'b0;
                for (int p = 0; p < pause_len; p++) begin
                    if (p > 0) begin
                        check_value("line_valid in pause", 0, int'(line_valid));
                    end
                    @(negedge clock);
                end
            end
            prbs_en = 1'b1;
        end
        @(negedge clock);
        prbs_en = 1'b0;
    endtask

    task automatic check_symbols(int count, int mode);
        int         noise;
        int         line;
        logic [1:0] pair;
        logic [1:0] rx_exp;
        for (int k = 0; k < count; k++) begin
            pair   = next_model_pair();
            noise  = (mode == mode_zero) ? 0 : int'($signed(mem_table[5'(k % table_depth)]));
            line   = clamp_level(symbol_level(gray_symbol(pair)) + noise);
            rx_exp = symbol_bits(slice_level(line));
            model_errors += $countones(rx_exp ^ pair);
            @(negedge clock);
            while (!line_valid) begin
                @(negedge clock);
            end
            check_value("line_level", line, int'($signed(line_level)));
            @(negedge clock);  // receiver output one cycle later
            check_value("rx_valid", 1, int'(rx_valid));
            check_value("rx_bits", int'(rx_exp), int'(rx_bits));
            check_value("error_count", model_errors, int'(error_count));
        end
    endtask

    task automatic run_row(int r);
        cur_test     = row_name[r];
        model_prbs   = 7'h7f;
        model_errors = 0;
        @(negedge clock);
        reset_n    = 1'b0;
        prbs_en    = 1'b0;
        noise_load = 1'b0;
        repeat (10) @(negedge clock);
        check_value("reset noise_ready", 0, int'(noise_ready));
        check_value("reset line_valid", 0, int'(line_valid));
        check_value("reset rx_valid", 0, int'(rx_valid));
        check_value("reset error_count", 0, int'(error_count));
        check_value("reset mem_addr", 0, int'(mem_addr));
        reset_n = 1'b1;
        if (row_mode[r] != mode_zero) begin
            fill_table(row_mode[r], row_amp[r]);
            load_noise();
        end
        fork
            drive_prbs(row_symbols[r], row_pause[r]);
            check_symbols(row_symbols[r], row_mode[r]);
        join
        repeat (drain_len) @(negedge clock);  // link idle after the last symbol
        check_value("final error_count", model_errors, int'(error_count));
    endtask

    // watchdog sized from the table
    initial begin
        int limit;
        limit = 200;  // margin
        for (int r = 0; r < row_total; r++) begin
            limit += 12 + drain_len + 4 * row_symbols[r];
            if (row_mode[r] != mode_zero) begin
                limit += table_depth + 8;
            end
            if (row_pause[r] != 0) begin
                limit += pause_len + 4;
            end
        end
        #(limit * 40);
        $display("watchdog expired after %0d clock cycles without finishing", limit);
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin
        clock      = 1'b0;
        reset_n    = 1'b0;
        prbs_en    = 1'b0;
        noise_load = 1'b0;
        rand_state = 32'h5248;
        for (int r = 0; r < row_total; r++) begin
            run_row(r);
        end
        $display("Test OK");
        $finish;
    end

endmodule

/* sources.f */
source/serdes_types_pkg.sv
source/noise_cfg_pkg.sv
source/pam4_transmitter.sv
source/noise_source.sv
source/channel_combiner.sv
source/pam4_receiver.sv
source/serdes_link.sv
sim/serdes_link_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the serdes link testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module serdes_link_tb \
    -Mdir obj_dir -o serdes_link_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/serdes_link_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Test OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
